// File: rtl/fir_defs.svh
`ifndef FIR_DEFS_SVH
`define FIR_DEFS_SVH

// width of one real or imaginary part.
`define FIR_DATA_SIZE 32

// fractional bits of the fixed-point format.
`define FIR_QUANT_BITS 10

`define FIR_NUM_TAPS 8
`define FIR_DECIMATION 4

// must divide the tap count.
`define FIR_UNROLL 2

// power of two.
`define FIR_FIFO_DEPTH 16

`endif

// File: rtl/fir_pkg.sv
`default_nettype none

`include "fir_defs.svh"

package fir_pkg;

    typedef struct packed {
        logic signed [`FIR_DATA_SIZE-1:0] re;
        logic signed [`FIR_DATA_SIZE-1:0] im;
    } cmplx_parts_t;

    // one FIFO word, flat or split into real and imaginary parts.
    typedef union packed {
        logic [2*`FIR_DATA_SIZE-1:0] raw;
        cmplx_parts_t parts;
    } cmplx_word_u;

    typedef logic signed [`FIR_DATA_SIZE-1:0] coeff_array_t [`FIR_NUM_TAPS];

    // low-pass taps in Q10, symmetric real part.
    localparam coeff_array_t coeff_re = '{
        32'sd57, 32'sd134, 32'sd301, 32'sd512,
        32'sd512, 32'sd301, 32'sd134, 32'sd57
    };

    // antisymmetric imaginary part.
    localparam coeff_array_t coeff_im = '{
        -32'sd20, 32'sd45, -32'sd88, 32'sd160,
        -32'sd160, 32'sd88, -32'sd45, 32'sd20
    };

    function automatic logic signed [`FIR_DATA_SIZE-1:0] dequant_mul(
        input logic signed [`FIR_DATA_SIZE-1:0] a,
        input logic signed [`FIR_DATA_SIZE-1:0] b
    );
        logic signed [2*`FIR_DATA_SIZE-1:0] product;
        logic signed [2*`FIR_DATA_SIZE-1:0] scaled;
        product = a * b;
        scaled = product >>> `FIR_QUANT_BITS;
        return scaled[`FIR_DATA_SIZE-1:0];
    endfunction

endpackage

`default_nettype wire

// File: rtl/sample_fifo_if.sv
`default_nettype none
`timescale 1ns/1ps

interface sample_fifo_if;

    // write side.
    logic wr_en;
    fir_pkg::cmplx_word_u din;
    logic full;

    // read side, dout valid while empty is low.
    logic rd_en;
    fir_pkg::cmplx_word_u dout;
    logic empty;

    modport writer (
        output wr_en, din,
        input  full
    );

    modport reader (
        output rd_en,
        input  dout, empty
    );

    modport fifo (
        input  wr_en, din, rd_en,
        output full, dout, empty
    );

endinterface

`default_nettype wire

// File: rtl/sample_fifo.sv
`default_nettype none
`timescale 1ns/1ps

`include "fir_defs.svh"

module sample_fifo (
    input logic clock,
    input logic reset,
    sample_fifo_if.fifo port
);

    localparam int DEPTH = `FIR_FIFO_DEPTH;
    localparam int WORD_W = 2 * `FIR_DATA_SIZE;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WORD_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_write;
    logic do_read;

    // illegal strobes are dropped here.
    assign do_write = port.wr_en && !port.full;
    assign do_read = port.rd_en && !port.empty;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= port.din.raw;
        end
    end

    // first word falls through.
    assign port.dout.raw = mem[rd_ptr];

    assign port.empty = (count == '0);
    assign port.full = (count == CNT_W'(DEPTH));

endmodule

`default_nettype wire

// File: rtl/fir_decimator.sv
`default_nettype none
`timescale 1ns/1ps

`include "fir_defs.svh"

module fir_decimator #(
    parameter fir_pkg::coeff_array_t COEFF_RE = fir_pkg::coeff_re,
    parameter fir_pkg::coeff_array_t COEFF_IM = fir_pkg::coeff_im
) (
    input logic clock,
    input logic reset,
    sample_fifo_if.reader samples,
    sample_fifo_if.writer results
);

    localparam int DATA_W = `FIR_DATA_SIZE;
    localparam int NUM_TAPS = `FIR_NUM_TAPS;
    localparam int DECIMATION = `FIR_DECIMATION;
    localparam int UNROLL = `FIR_UNROLL;
    localparam int DEC_W = $clog2(DECIMATION) + 1;
    localparam int TAP_W = $clog2(NUM_TAPS) + 1;

    // st_shift doubles as idle.
    typedef enum logic [1:0] {
        st_shift,
        st_mult,
        st_accum,
        st_write
    } state_t;

    state_t state;
    state_t next_state;

    logic [DEC_W-1:0] dec_cnt;
    logic [TAP_W-1:0] tap_cnt;

    logic signed [DATA_W-1:0] x_re [NUM_TAPS];
    logic signed [DATA_W-1:0] x_im [NUM_TAPS];

    // re*re, im*im, re*im and im*re partial products.
    logic signed [DATA_W-1:0] prod_rr [NUM_TAPS];
    logic signed [DATA_W-1:0] prod_ii [NUM_TAPS];
    logic signed [DATA_W-1:0] prod_ri [NUM_TAPS];
    logic signed [DATA_W-1:0] prod_ir [NUM_TAPS];

    logic signed [DATA_W-1:0] sum_re;
    logic signed [DATA_W-1:0] sum_im;
    logic signed [DATA_W-1:0] acc_re;
    logic signed [DATA_W-1:0] acc_im;

    always_comb begin
        next_state = state;
        samples.rd_en = 1'b0;
        results.wr_en = 1'b0;
        case (state)
            st_shift: begin
                if (!samples.empty) begin
                    samples.rd_en = 1'b1;
                    if (dec_cnt == DEC_W'(DECIMATION - 1)) begin
                        next_state = st_mult;
                    end
                end
            end
            st_mult: begin
                if (tap_cnt == TAP_W'(NUM_TAPS - UNROLL)) begin
                    next_state = st_accum;
                end
            end
            st_accum: begin
                next_state = st_write;
            end
            st_write: begin
                // hold here while the output side is full.
                if (!results.full) begin
                    results.wr_en = 1'b1;
                    next_state = st_shift;
                end
            end
            default: begin
                next_state = st_shift;
            end
        endcase
    end

    // full adder tree over all taps, sums wrap.
    always_comb begin
        acc_re = sum_re;
        acc_im = sum_im;
        for (int t = 0; t < NUM_TAPS; t++) begin
            acc_re = acc_re + prod_rr[t] - prod_ii[t];
            acc_im = acc_im + prod_ri[t] + prod_ir[t];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_shift;
            dec_cnt <= '0;
            tap_cnt <= '0;
            sum_re <= '0;
            sum_im <= '0;
            for (int t = 0; t < NUM_TAPS; t++) begin
                x_re[t] <= '0;
                x_im[t] <= '0;
            end
        end else begin
            state <= next_state;
            case (state)
                st_shift: begin
                    if (samples.rd_en) begin
                        for (int t = NUM_TAPS - 1; t > 0; t--) begin
                            x_re[t] <= x_re[t-1];
                            x_im[t] <= x_im[t-1];
                        end
                        x_re[0] <= samples.dout.parts.re;
                        x_im[0] <= samples.dout.parts.im;
                        dec_cnt <= dec_cnt + 1'b1;
                    end
                end
                st_mult: begin
                    tap_cnt <= tap_cnt + TAP_W'(UNROLL);
                end
                st_accum: begin
                    sum_re <= acc_re;
                    sum_im <= acc_im;
                end
                st_write: begin
                    if (results.wr_en) begin
                        sum_re <= '0;
                        sum_im <= '0;
                        dec_cnt <= '0;
                        tap_cnt <= '0;
                    end
                end
                default: ;
            endcase
        end
    end

    // UNROLL taps per cycle.
    always_ff @(posedge clock) begin
        if (state == st_mult) begin
            for (int u = 0; u < UNROLL; u++) begin
                prod_rr[tap_cnt + u] <= fir_pkg::dequant_mul(
                    x_re[tap_cnt + u], COEFF_RE[tap_cnt + u]);
                prod_ii[tap_cnt + u] <= fir_pkg::dequant_mul(
                    x_im[tap_cnt + u], COEFF_IM[tap_cnt + u]);
                prod_ri[tap_cnt + u] <= fir_pkg::dequant_mul(
                    x_re[tap_cnt + u], COEFF_IM[tap_cnt + u]);
                prod_ir[tap_cnt + u] <= fir_pkg::dequant_mul(
                    x_im[tap_cnt + u], COEFF_RE[tap_cnt + u]);
            end
        end
    end

    assign results.din.parts.re = sum_re;
    assign results.din.parts.im = sum_im;

endmodule

`default_nettype wire

// File: rtl/fir_chain_top.sv
`default_nettype none
`timescale 1ns/1ps

module fir_chain_top (
    input  logic clock,
    input  logic reset,
    input  logic in_wr_en,
    input  logic signed [31:0] in_re,
    input  logic signed [31:0] in_im,
    output logic in_full,
    input  logic out_rd_en,
    output logic signed [31:0] out_re,
    output logic signed [31:0] out_im,
    output logic out_empty
);

    fir_pkg::cmplx_word_u in_word;
    fir_pkg::cmplx_word_u out_word;

    sample_fifo_if in_fifo_if ();
    sample_fifo_if out_fifo_if ();

    // producer side.
    always_comb begin
        in_word.parts.re = in_re;
        in_word.parts.im = in_im;
    end

    assign in_fifo_if.wr_en = in_wr_en;
    assign in_fifo_if.din = in_word;
    assign in_full = in_fifo_if.full;

    // caller pops results here.
    assign out_fifo_if.rd_en = out_rd_en;
    assign out_word = out_fifo_if.dout;
    assign out_re = out_word.parts.re;
    assign out_im = out_word.parts.im;
    assign out_empty = out_fifo_if.empty;

    sample_fifo in_fifo (
        .clock (clock),
        .reset (reset),
        .port  (in_fifo_if.fifo)
    );

    fir_decimator filter (
        .clock   (clock),
        .reset   (reset),
        .samples (in_fifo_if.reader),
        .results (out_fifo_if.writer)
    );

    sample_fifo out_fifo (
        .clock (clock),
        .reset (reset),
        .port  (out_fifo_if.fifo)
    );

endmodule

`default_nettype wire

// File: verif/fir_chain_assert.sv
`default_nettype none
`timescale 1ns/1ps

module fir_chain_assert (
    input logic clock,
    input logic reset,
    sample_fifo_if in_bus,
    sample_fifo_if out_bus,
    input logic [1:0] filter_state
);

    // shift state is the filter's idle state, encoded as zero.
    localparam logic [1:0] FILTER_IDLE = 2'd0;

    int failures = 0;

    in_write_not_full: assert property (
        @(posedge clock) disable iff (reset) in_bus.wr_en |-> !in_bus.full
    ) else begin
        $error("write strobe on a full input FIFO");
        failures++;
    end

    out_write_not_full: assert property (
        @(posedge clock) disable iff (reset) out_bus.wr_en |-> !out_bus.full
    ) else begin
        $error("write strobe on a full output FIFO");
        failures++;
    end

    in_pop_not_empty: assert property (
        @(posedge clock) disable iff (reset) in_bus.rd_en |-> !in_bus.empty
    ) else begin
        $error("pop from an empty input FIFO");
        failures++;
    end

    out_pop_not_empty: assert property (
        @(posedge clock) disable iff (reset) out_bus.rd_en |-> !out_bus.empty
    ) else begin
        $error("pop from an empty output FIFO");
        failures++;
    end

    // a full input with nothing out means the filter stalled.
    no_idle_stall: assert property (
        @(posedge clock) disable iff (reset)
            !(in_bus.full && out_bus.empty && filter_state == FILTER_IDLE)
    ) else begin
        $error("input full and output empty while the filter sits idle");
        failures++;
    end

    empty_in_reset: assert property (
        @(posedge clock) reset |-> out_bus.empty
    ) else begin
        $error("output FIFO not empty during reset");
        failures++;
    end

endmodule

bind fir_chain_top fir_chain_assert protocol_checks (
    .clock        (clock),
    .reset        (reset),
    .in_bus       (in_fifo_if),
    .out_bus      (out_fifo_if),
    .filter_state (filter.state)
);

`default_nettype wire

// File: verif/fir_chain_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "fir_defs.svh"

module fir_chain_tb;

    localparam int NUM_TAPS = `FIR_NUM_TAPS;
    localparam int DECIMATION = `FIR_DECIMATION;
    localparam int TOTAL_SAMPLES = 8 + 8 + 64 + 96;
    localparam int TIMEOUT_CYCLES = TOTAL_SAMPLES * 4 + 2000;

    logic clock;
    logic reset;
    logic in_wr_en;
    logic signed [31:0] in_re;
    logic signed [31:0] in_im;
    logic in_full;
    logic out_rd_en;
    logic signed [31:0] out_re;
    logic signed [31:0] out_im;
    logic out_empty;

    logic hold_output;
    logic full_seen;
    integer seed;
    int cycle_count;
    int taken;
    logic signed [31:0] line_re [NUM_TAPS];
    logic signed [31:0] line_im [NUM_TAPS];
    logic [63:0] expected_q [$];
    logic [63:0] impulse_q [$];

    fir_chain_top fir_chain_top_i (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_re     (in_re),
        .in_im     (in_im),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_re    (out_re),
        .out_im    (out_im),
        .out_empty (out_empty)
    );

    always #4 clock = ~clock;

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // each write is followed by an idle cycle so in_full can settle.
    task automatic push_sample(input logic signed [31:0] re, input logic signed [31:0] im);
        @(posedge clock);
        while (in_full) begin
            @(posedge clock);
        end
        in_wr_en <= 1'b1;
        in_re <= re;
        in_im <= im;
        @(posedge clock);
        in_wr_en <= 1'b0;
    endtask

    task automatic push_random(input int count);
        for (int n = 0; n < count; n++) begin
            push_sample($random(seed) % 16384, $random(seed) % 16384);
        end
    endtask

    // a unit impulse picks out every DECIMATION-th tap.
    task automatic expect_impulse(input logic on_imag);
        logic signed [31:0] c_re;
        logic signed [31:0] c_im;
        for (int t = DECIMATION - 1; t < NUM_TAPS; t += DECIMATION) begin
            c_re = fir_pkg::coeff_re[t];
            c_im = fir_pkg::coeff_im[t];
            if (on_imag) begin
                impulse_q.push_back({-c_im, c_re});
            end else begin
                impulse_q.push_back({c_re, c_im});
            end
        end
    endtask

    task automatic check_result(input logic [63:0] want);
        assert (out_re == want[63:32]) else begin
            $display("error out_re expected %h got %h", want[63:32], out_re);
            abort_run();
        end
        assert (out_im == want[31:0]) else begin
            $display("error out_im expected %h got %h", want[31:0], out_im);
            abort_run();
        end
    endtask

    task automatic wait_drained();
        @(posedge clock);
        while (expected_q.size() != 0) begin
            @(posedge clock);
        end
    endtask

    // newest sample in slot 0.
    always @(posedge clock) begin : reference_model
        logic signed [31:0] exp_re;
        logic signed [31:0] exp_im;
        if (in_wr_en && !in_full) begin
            for (int t = NUM_TAPS - 1; t > 0; t--) begin
                line_re[t] = line_re[t-1];
                line_im[t] = line_im[t-1];
            end
            line_re[0] = in_re;
            line_im[0] = in_im;
            taken++;
            if (taken % DECIMATION == 0) begin
                exp_re = '0;
                exp_im = '0;
                for (int t = 0; t < NUM_TAPS; t++) begin
                    exp_re = exp_re + fir_pkg::dequant_mul(line_re[t], fir_pkg::coeff_re[t])
                        - fir_pkg::dequant_mul(line_im[t], fir_pkg::coeff_im[t]);
                    exp_im = exp_im + fir_pkg::dequant_mul(line_re[t], fir_pkg::coeff_im[t])
                        + fir_pkg::dequant_mul(line_im[t], fir_pkg::coeff_re[t]);
                end
                expected_q.push_back({exp_re, exp_im});
            end
        end
    end

    always @(posedge clock) begin : compare_outputs
        logic [63:0] head;
        if (out_rd_en && !out_empty) begin
            assert (expected_q.size() != 0) else begin
                $display("error: a result came out that the model never produced");
                abort_run();
            end
            head = expected_q.pop_front();
            check_result(head);
            if (impulse_q.size() != 0) begin
                head = impulse_q.pop_front();
                check_result(head);
            end
        end
    end

    // pops every other cycle while results are not held.
    always @(posedge clock) begin
        if (out_rd_en) begin
            out_rd_en <= 1'b0;
        end else if (!hold_output && !out_empty && !reset) begin
            out_rd_en <= 1'b1;
        end
        if (hold_output && in_full) begin
            full_seen <= 1'b1;
            hold_output <= 1'b0;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("error timeout: outputs never arrived");
            abort_run();
        end else if (fir_chain_top_i.protocol_checks.failures != 0) begin
            $display("error: a protocol assertion failed");
            abort_run();
        end
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        in_wr_en = 1'b0;
        in_re = '0;
        in_im = '0;
        out_rd_en = 1'b0;
        hold_output = 1'b0;
        full_seen = 1'b0;
        seed = 79;
        cycle_count = 0;
        taken = 0;
        for (int t = 0; t < NUM_TAPS; t++) begin
            line_re[t] = '0;
            line_im[t] = '0;
        end
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        assert (out_empty == 1'b1) else begin
            $display("error out_empty expected 1 got %h", out_empty);
            abort_run();
        end
        assert (in_full == 1'b0) else begin
            $display("error in_full expected 0 got %h", in_full);
            abort_run();
        end

        // real impulse.
        expect_impulse(1'b0);
        push_sample(32'sd1 <<< `FIR_QUANT_BITS, '0);
        repeat (7) push_sample('0, '0);
        wait_drained();

        // imaginary impulse lands on the cross terms.
        expect_impulse(1'b1);
        push_sample('0, 32'sd1 <<< `FIR_QUANT_BITS);
        repeat (7) push_sample('0, '0);
        wait_drained();

        push_random(64);
        wait_drained();

        hold_output <= 1'b1;
        push_random(96);
        assert (full_seen) else begin
            $display("error: in_full never rose while results were held");
            abort_run();
        end
        wait_drained();
        @(posedge clock);
        if (!out_empty) begin
            $display("error out_empty expected 1 got %h", out_empty);
            abort_run();
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+rtl
rtl/fir_pkg.sv
rtl/sample_fifo_if.sv
rtl/sample_fifo.sv
rtl/fir_decimator.sv
rtl/fir_chain_top.sv
verif/fir_chain_assert.sv
verif/fir_chain_tb.sv
